// File: verilog/trg_pkg.sv
package trg_pkg;

  // stream word and lane layout
  localparam int tdata_width = 128;
  localparam int lane_count  = 8;
  localparam int lane_width  = 16;
  localparam int adc_width   = 12;
  localparam int pad_width   = lane_width - adc_width;

  // time base and event counter
  localparam int time_width  = 48;
  localparam int count_width = 16;

  // window lengths, in stream words
  localparam int post_acqui_len = 38;
  localparam int acqui_len      = 100;

  // counter widths, wide enough to hold the full length
  localparam int post_cnt_width = $clog2(post_acqui_len + 1);
  localparam int acq_cnt_width  = $clog2(acqui_len + 1);

  // one lane slot, sample in the upper bits
  typedef struct packed {
    logic signed [adc_width-1:0] sample;
    logic [pad_width-1:0]        pad;
  } lane_t;

  // raw view for pass-through, lane view for compare and pad clearing
  typedef union packed {
    logic [tdata_width-1:0]   raw;
    lane_t [lane_count-1:0]   lane;
  } lane_word_u;

  typedef struct packed {
    lane_word_u                  word;
    logic                        valid;
    logic [lane_count-1:0]       hits;
    logic [time_width-1:0]       cur_time;
    logic signed [adc_width-1:0] baseline;
    logic signed [adc_width:0]   threshold;
  } unpack_t;

  typedef struct packed {
    logic [tdata_width-1:0]      data;
    logic                        valid;
    logic                        triggered;
    logic                        rise;
    logic [time_width-1:0]       cur_time;
    logic signed [adc_width-1:0] baseline;
    logic signed [adc_width:0]   threshold;
  } trig_t;

  typedef struct packed {
    logic [time_width-1:0]       time_stamp;
    logic signed [adc_width-1:0] baseline_when_hit;
    logic signed [adc_width:0]   threshold_when_hit;
  } capture_t;

endpackage

// File: verilog/sample_unpack.sv
`timescale 1ns/1ps

module sample_unpack (
  input  logic                                 CLK,
  input  logic                                 RESETN,
  input  trg_pkg::lane_word_u                  tdata,
  input  logic                                 tvalid,
  input  logic signed [trg_pkg::adc_width-1:0] baseline,
  input  logic signed [trg_pkg::adc_width:0]   threshold_val,
  input  logic [trg_pkg::time_width-1:0]       current_time,
  output trg_pkg::unpack_t                     stage
);

  // sample minus baseline, one extra bit so it cannot wrap
  logic signed [trg_pkg::adc_width:0] delta [trg_pkg::lane_count];
  logic [trg_pkg::lane_count-1:0]     hit_d;

  // control state
  logic                               valid_q;
  logic [trg_pkg::lane_count-1:0]     hits_q;

  // payload, follows the input every clock
  trg_pkg::lane_word_u                word_q;
  logic [trg_pkg::time_width-1:0]     time_q;
  logic signed [trg_pkg::adc_width-1:0] baseline_q;
  logic signed [trg_pkg::adc_width:0]   threshold_q;

  always_comb begin
    for (int i = 0; i < trg_pkg::lane_count; i++) begin
      // sign extend both operands to 13 bits before subtracting
      delta[i] = {tdata.lane[i].sample[trg_pkg::adc_width-1], tdata.lane[i].sample}
                 - {baseline[trg_pkg::adc_width-1], baseline};
      hit_d[i] = (delta[i] >= threshold_val);
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      valid_q <= 1'b0;
      hits_q  <= '0;
    end else begin
      valid_q <= tvalid;
      // an invalid word never hits
      hits_q  <= tvalid ? hit_d : '0;
    end
  end

  always_ff @(posedge CLK) begin
    word_q      <= tdata;
    time_q      <= current_time;
    baseline_q  <= baseline;
    threshold_q <= threshold_val;
  end

  assign stage = '{
    word:      word_q,
    valid:     valid_q,
    hits:      hits_q,
    cur_time:  time_q,
    baseline:  baseline_q,
    threshold: threshold_q
  };

endmodule

// File: verilog/hit_trigger.sv
`timescale 1ns/1ps

module hit_trigger (
  input  logic             CLK,
  input  logic             RESETN,
  input  trg_pkg::unpack_t stage_in,
  output trg_pkg::trig_t   stage_out
);

  // word-level hit and its edges
  logic hit;
  logic hit_prev;
  logic rise;
  logic fall;

  // post window after the last hit word
  logic [trg_pkg::post_cnt_width-1:0] post_cnt;
  logic [trg_pkg::post_cnt_width-1:0] post_next;
  logic                               post_open;
  logic                               post_win;

  // acquisition length, index of the current word from the rising edge
  logic [trg_pkg::acq_cnt_width-1:0]  acq_cnt;
  logic [trg_pkg::acq_cnt_width-1:0]  acq_idx;
  logic                               over_len;

  logic                               trig_d;
  trg_pkg::lane_word_u                cleared;
  logic [trg_pkg::tdata_width-1:0]    data_d;

  // output registers
  logic                               valid_q;
  logic                               triggered_q;
  logic                               rise_q;
  logic [trg_pkg::tdata_width-1:0]    data_q;
  logic [trg_pkg::time_width-1:0]     time_q;
  logic signed [trg_pkg::adc_width-1:0] baseline_q;
  logic signed [trg_pkg::adc_width:0]   threshold_q;

  assign hit  = stage_in.valid & (|stage_in.hits);
  assign rise = hit & ~hit_prev;
  // first quiet word after a hit run
  assign fall = stage_in.valid & ~hit & hit_prev;

  assign post_win  = fall | post_open;
  assign post_next = post_cnt + 1'b1;

  // edge word counts as index 0
  assign acq_idx = rise ? '0 : acq_cnt;

  // a new edge lifts a previous cut
  assign trig_d = stage_in.valid & (hit | post_win) & (rise | ~over_len);

  always_comb begin
    cleared = stage_in.word;
    for (int i = 0; i < trg_pkg::lane_count; i++) begin
      cleared.lane[i].pad = '0;
    end
  end

  assign data_d = stage_in.valid ? cleared.raw : '1;

  // hit history, an invalid word leaves it clear
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      hit_prev <= 1'b0;
    end else begin
      hit_prev <= hit;
    end
  end

  // post counter restarts on every hit word
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      post_cnt  <= '0;
      post_open <= 1'b0;
    end else if (!stage_in.valid || hit) begin
      post_cnt  <= '0;
      post_open <= 1'b0;
    end else if (post_win) begin
      post_cnt  <= post_next;
      post_open <= (post_next < trg_pkg::post_acqui_len);
    end
  end

  // saturating acquisition counter and the over-length cut
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      acq_cnt  <= '0;
      over_len <= 1'b0;
    end else if (stage_in.valid) begin
      if (acq_idx == trg_pkg::acqui_len) begin
        acq_cnt <= acq_idx;
      end else begin
        acq_cnt <= acq_idx + 1'b1;
      end
      // next word would be past the maximum length
      over_len <= (acq_idx >= trg_pkg::acqui_len - 1);
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      valid_q     <= 1'b0;
      triggered_q <= 1'b0;
      rise_q      <= 1'b0;
    end else begin
      valid_q     <= stage_in.valid;
      triggered_q <= trig_d;
      rise_q      <= rise;
    end
  end

  always_ff @(posedge CLK) begin
    data_q      <= data_d;
    time_q      <= stage_in.cur_time;
    baseline_q  <= stage_in.baseline;
    threshold_q <= stage_in.threshold;
  end

  assign stage_out = '{
    data:      data_q,
    valid:     valid_q,
    triggered: triggered_q,
    rise:      rise_q,
    cur_time:  time_q,
    baseline:  baseline_q,
    threshold: threshold_q
  };

endmodule

// File: verilog/event_capture.sv
`timescale 1ns/1ps

module event_capture (
  input  logic                              CLK,
  input  logic                              RESETN,
  input  trg_pkg::trig_t                    stage_in,
  output logic [trg_pkg::tdata_width-1:0]   data,
  output logic                              valid,
  output logic                              triggered,
  output trg_pkg::capture_t                 event_rec,
  output logic [trg_pkg::count_width-1:0]   event_count
);

  // stream outputs, one clock behind the trigger stage
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      data      <= '1;
      valid     <= 1'b0;
      triggered <= 1'b0;
    end else begin
      data      <= stage_in.data;
      valid     <= stage_in.valid;
      triggered <= stage_in.triggered;
    end
  end

  // event record, held between rising edges
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      event_rec <= '0;
    end else if (stage_in.rise) begin
      event_rec <= '{
        time_stamp:         stage_in.cur_time,
        baseline_when_hit:  stage_in.baseline,
        threshold_when_hit: stage_in.threshold
      };
    end
  end

  // saturates instead of wrapping
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      event_count <= '0;
    end else if (stage_in.rise && (event_count != {trg_pkg::count_width{1'b1}})) begin
      event_count <= event_count + 1'b1;
    end
  end

endmodule

// File: verilog/trigger_top.sv
`timescale 1ns/1ps

module trigger_top (
  input  logic                                 CLK,
  input  logic                                 RESETN,
  input  logic [trg_pkg::tdata_width-1:0]      tdata,
  input  logic                                 tvalid,
  input  logic signed [trg_pkg::adc_width-1:0] baseline,
  input  logic signed [trg_pkg::adc_width:0]   threshold_val,
  input  logic [trg_pkg::time_width-1:0]       current_time,
  output logic [trg_pkg::tdata_width-1:0]      data,
  output logic                                 valid,
  output logic                                 triggered,
  output logic [trg_pkg::time_width-1:0]       time_stamp,
  output logic signed [trg_pkg::adc_width-1:0] baseline_when_hit,
  output logic signed [trg_pkg::adc_width:0]   threshold_when_hit,
  output logic [trg_pkg::count_width-1:0]      event_count
);

  trg_pkg::lane_word_u tdata_u;
  trg_pkg::unpack_t    unpacked;
  trg_pkg::trig_t      trig;
  trg_pkg::capture_t   capture;

  assign tdata_u.raw = tdata;

  sample_unpack u_unpack (
    .CLK           (CLK),
    .RESETN        (RESETN),
    .tdata         (tdata_u),
    .tvalid        (tvalid),
    .baseline      (baseline),
    .threshold_val (threshold_val),
    .current_time  (current_time),
    .stage         (unpacked)
  );

  hit_trigger u_trigger (
    .CLK       (CLK),
    .RESETN    (RESETN),
    .stage_in  (unpacked),
    .stage_out (trig)
  );

  event_capture u_capture (
    .CLK         (CLK),
    .RESETN      (RESETN),
    .stage_in    (trig),
    .data        (data),
    .valid       (valid),
    .triggered   (triggered),
    .event_rec   (capture),
    .event_count (event_count)
  );

  // event record split out to plain ports
  assign time_stamp         = capture.time_stamp;
  assign baseline_when_hit  = capture.baseline_when_hit;
  assign threshold_when_hit = capture.threshold_when_hit;

endmodule

// File: testbench/trigger_properties.sv
`timescale 1ns/1ps

module trigger_properties (
  input logic             CLK,
  input logic             RESETN,
  input trg_pkg::unpack_t stage_in,
  input trg_pkg::trig_t   stage_out
);

  logic       word_hit;
  logic [7:0] since_hit;
  logic       in_window_q;

  assign word_hit = stage_in.valid && (|stage_in.hits);

  // words since the last hit, aligned with stage_out
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      since_hit   <= 8'hff;
      in_window_q <= 1'b0;
    end else begin
      if (!stage_in.valid) since_hit <= 8'hff;
      else if (word_hit) since_hit <= 8'h00;
      else if (since_hit != 8'hff) since_hit <= since_hit + 8'h01;
      in_window_q <= stage_in.valid && (word_hit ||
                     (since_hit != 8'hff && (int'(since_hit) + 1) <= trg_pkg::post_acqui_len));
    end
  end

  a_trig_needs_valid: assert property (@(posedge CLK) disable iff (!RESETN)
    !stage_out.valid |-> !stage_out.triggered)
    else $error("triggered high on an invalid word");

  a_rise_one_cycle: assert property (@(posedge CLK) disable iff (!RESETN)
    stage_out.rise |=> !stage_out.rise)
    else $error("rise strobe longer than one cycle");

  a_trig_in_window: assert property (@(posedge CLK) disable iff (!RESETN)
    $rose(stage_out.triggered) |-> in_window_q)
    else $error("triggered rose outside a hit window");

endmodule

bind hit_trigger trigger_properties u_props (
  .CLK       (CLK),
  .RESETN    (RESETN),
  .stage_in  (stage_in),
  .stage_out (stage_out)
);

// File: testbench/trigger_checker.sv
`timescale 1ns/1ps

module trigger_checker (
  input logic                                 CLK,
  input logic                                 RESETN,
  input logic [trg_pkg::tdata_width-1:0]      tdata,
  input logic                                 tvalid,
  input logic signed [trg_pkg::adc_width-1:0] baseline,
  input logic signed [trg_pkg::adc_width:0]   threshold_val,
  input logic [trg_pkg::time_width-1:0]       current_time,
  input logic [trg_pkg::tdata_width-1:0]      data,
  input logic                                 valid,
  input logic                                 triggered,
  input logic [trg_pkg::time_width-1:0]       time_stamp,
  input logic signed [trg_pkg::adc_width-1:0] baseline_when_hit,
  input logic signed [trg_pkg::adc_width:0]   threshold_when_hit,
  input logic [trg_pkg::count_width-1:0]      event_count
);

  localparam int far = 1000;

  typedef struct packed {
    logic [trg_pkg::tdata_width-1:0]      data;
    logic                                 valid;
    logic                                 triggered;
    logic [trg_pkg::time_width-1:0]       ts;
    logic signed [trg_pkg::adc_width-1:0] bl;
    logic signed [trg_pkg::adc_width:0]   thr;
    logic [trg_pkg::count_width-1:0]      cnt;
  } expect_t;

  expect_t pending[$];
  expect_t cur;
  expect_t rec;
  bit      have_cur = 0;

  // model state
  bit prev_hit  = 0;
  int since_hit = far;
  int edge_dist = far;

  int test_count   = 0;
  int checks       = 0;
  int errors       = 0;
  int total_checks = 0;
  int total_errors = 0;

  function automatic bit word_hits(input logic [trg_pkg::tdata_width-1:0] w,
                                   input logic signed [11:0] bl,
                                   input logic signed [12:0] thr);
    logic signed [11:0] s;
    logic signed [12:0] d;
    bit any;
    any = 0;
    for (int i = 0; i < trg_pkg::lane_count; i++) begin
      s = w[16*i+4 +: 12];
      d = {s[11], s} - {bl[11], bl};
      if (d >= thr) any = 1;
    end
    return any;
  endfunction

  function automatic logic [127:0] clear_pads(input logic [127:0] w);
    logic [127:0] r;
    r = w;
    for (int i = 0; i < trg_pkg::lane_count; i++) r[16*i +: 4] = 4'h0;
    return r;
  endfunction

  initial begin
    rec = '0;
    rec.data = '1;
    // pipeline contents right after reset
    repeat (2) pending.push_back(rec);
  end

  always @(posedge CLK) begin
    bit h;
    bit rise;
    bit post;
    expect_t e;
    if (RESETN) begin
      h    = tvalid && word_hits(tdata, baseline, threshold_val);
      rise = h && !prev_hit;
      if (!tvalid) since_hit = far;
      else if (h) since_hit = 0;
      else if (since_hit < far) since_hit++;
      post = tvalid && !h && (since_hit <= trg_pkg::post_acqui_len);
      if (rise) edge_dist = 0;
      else if (tvalid && edge_dist < far) edge_dist++;
      prev_hit = h;
      if (rise) begin
        rec.ts  = current_time;
        rec.bl  = baseline;
        rec.thr = threshold_val;
        if (rec.cnt != '1) rec.cnt = rec.cnt + 1'b1;
      end
      e = rec;
      e.valid     = tvalid;
      e.triggered = tvalid && (h || post) && (edge_dist < trg_pkg::acqui_len);
      e.data      = tvalid ? clear_pads(tdata) : '1;
      pending.push_back(e);
      if (pending.size() > 2) begin
        cur = pending.pop_front();
        have_cur = 1;
      end
    end
  end

  task automatic compare(input string what, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  // outputs are stable in the middle of the cycle
  always @(negedge CLK) begin
    if (have_cur) begin
      have_cur = 0;
      compare("data", data, cur.data);
      compare("valid", 128'(valid), 128'(cur.valid));
      compare("triggered", 128'(triggered), 128'(cur.triggered));
      compare("time_stamp", 128'(time_stamp), 128'(cur.ts));
      compare("baseline_when_hit", 128'(baseline_when_hit), 128'(cur.bl));
      compare("threshold_when_hit", 128'(threshold_when_hit), 128'(cur.thr));
      compare("event_count", 128'(event_count), 128'(cur.cnt));
    end
  end

  task automatic end_test(input string name);
    if (errors == 0) $display("test %-12s pass (%0d checks)", name, checks);
    else $display("test %-12s fail (%0d mismatches)", name, errors);
    test_count++;
    total_checks += checks;
    total_errors += errors;
    checks = 0;
    errors = 0;
  endtask

endmodule

// File: testbench/tb_trigger.sv
`timescale 1ns/1ps

module tb_trigger;

  localparam int clk_period = 100;

  // words per test
  localparam int idle_words  = 60;
  localparam int cmp_words   = 200;
  localparam int post_reps   = 4;
  localparam int post_burst  = 3;
  localparam int post_quiet  = 50;
  localparam int cut_run     = 130;
  localparam int cut_quiet   = 20;
  localparam int cut_tail    = 5;
  localparam int cut_end     = 50;
  localparam int cap_reps    = 6;
  localparam int cap_quiet   = 45;
  localparam int gap_words   = 300;
  localparam int drain_words = 4;
  localparam int margin      = 100;
  localparam int total_words = idle_words + cmp_words + post_reps * (post_burst + post_quiet)
                             + cut_run + cut_quiet + cut_tail + cut_end
                             + cap_reps * (2 + cap_quiet) + gap_words + 6 * drain_words + 2;

  logic                                 CLK;
  logic                                 RESETN;
  logic [trg_pkg::tdata_width-1:0]      tdata;
  logic                                 tvalid;
  logic signed [trg_pkg::adc_width-1:0] baseline;
  logic signed [trg_pkg::adc_width:0]   threshold_val;
  logic [trg_pkg::time_width-1:0]       current_time = '0;
  logic [trg_pkg::tdata_width-1:0]      data;
  logic                                 valid;
  logic                                 triggered;
  logic [trg_pkg::time_width-1:0]       time_stamp;
  logic signed [trg_pkg::adc_width-1:0] baseline_when_hit;
  logic signed [trg_pkg::adc_width:0]   threshold_when_hit;
  logic [trg_pkg::count_width-1:0]      event_count;

  trigger_top i_dut (.*);

  trigger_checker u_checker (.*);

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  // free running time base
  always @(negedge CLK) begin
    current_time <= current_time + 1'b1;
  end

  initial begin
    #((total_words + margin) * clk_period);
    $display("watchdog: run did not finish within the expected time");
    $display("Simulation FAILED");
    $finish;
  end

  // moderate baseline and threshold so quiet samples never hit
  task automatic new_settings();
    baseline      = 12'(int'($urandom % 201) - 100);
    threshold_val = 13'(200 + int'($urandom % 401));
  endtask

  task automatic send_word(input bit v, input bit h);
    logic [trg_pkg::tdata_width-1:0] w;
    int k;
    @(negedge CLK);
    k = int'($urandom % 8);
    for (int i = 0; i < trg_pkg::lane_count; i++) begin
      w[16*i+4 +: 12] = 12'(int'(baseline) + int'($urandom % 400) - 200);
      w[16*i +: 4]    = 4'($urandom);
    end
    if (h) begin
      w[16*k+4 +: 12] = 12'(int'(baseline) + int'(threshold_val) + int'($urandom % 3));
    end
    tdata  = w;
    tvalid = v;
  endtask

  // unrestricted values, sometimes exactly on the threshold
  task automatic send_random();
    logic [trg_pkg::adc_width-1:0] edge_smp;
    int j;
    @(negedge CLK);
    tdata         = {$urandom, $urandom, $urandom, $urandom};
    baseline      = 12'($urandom);
    threshold_val = 13'($urandom);
    tvalid        = 1'b1;
    j = int'($urandom % 8);
    edge_smp = baseline + threshold_val[trg_pkg::adc_width-1:0];
    if ($urandom % 4 == 0) begin
      tdata[16*j+4 +: 12] = edge_smp;
    end
  endtask

  task automatic finish_test(input string name);
    repeat (drain_words) send_word(1'b1, 1'b0);
    // tally after the compare on the last negedge
    @(posedge CLK);
    u_checker.end_test(name);
  endtask

  initial begin
    void'($urandom(57));
    RESETN        = 1'b0;
    tdata         = '0;
    tvalid        = 1'b0;
    baseline      = '0;
    threshold_val = 13'sd300;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RESETN = 1'b1;

    new_settings();
    repeat (idle_words) send_word(1'b1, 1'b0);
    finish_test("idle");

    repeat (cmp_words) send_random();
    new_settings();
    finish_test("threshold");

    for (int r = 0; r < post_reps; r++) begin
      repeat (post_burst) send_word(1'b1, 1'b1);
      repeat (post_quiet) send_word(1'b1, 1'b0);
    end
    finish_test("post_window");

    repeat (cut_run) send_word(1'b1, 1'b1);
    repeat (cut_quiet) send_word(1'b1, 1'b0);
    repeat (cut_tail) send_word(1'b1, 1'b1);
    repeat (cut_end) send_word(1'b1, 1'b0);
    finish_test("length_cut");

    for (int r = 0; r < cap_reps; r++) begin
      new_settings();
      repeat (2) send_word(1'b1, 1'b1);
      repeat (cap_quiet) send_word(1'b1, 1'b0);
    end
    finish_test("capture");

    repeat (gap_words) send_word(($urandom % 5) != 0, ($urandom % 3) == 0);
    finish_test("valid_gaps");

    $display("summary: %0d tests, %0d checks, %0d mismatches",
             u_checker.test_count, u_checker.total_checks, u_checker.total_errors);
    if (u_checker.total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/trg_pkg.sv
verilog/sample_unpack.sv
verilog/hit_trigger.sv
verilog/event_capture.sv
verilog/trigger_top.sv
testbench/trigger_properties.sv
testbench/trigger_checker.sv
testbench/tb_trigger.sv

// File: Makefile
# Verilator build and run for the trigger front end

VERILATOR ?= verilator
TOP       ?= tb_trigger
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -e "Simulation FAILED" -e "%Error" $(LOG); then \
		echo "test failed"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "test did not complete"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
